// File: flist.f
+incdir+verification
hdl/mipsIsaPkg.sv
hdl/mipsCfgPkg.sv
hdl/fetchUnit.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/dataMemory.sv
hdl/singleCycleCore.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
# build the core testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module coreTb -f flist.f -o coreTbSim \
    && ./obj_dir/coreTbSim > sim.log 2>&1 \
    || echo "build or simulation stopped early"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/coreTbPrograms.svh
`ifndef CORE_TB_PROGRAMS_SVH
`define CORE_TB_PROGRAMS_SVH

// ---------------------------------------------------------------------------
// instruction encoders
// ---------------------------------------------------------------------------
function automatic logic [31:0] encodeR(functT fn, int rd, int rs, int rt, int sh);
    return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] encodeI(opcodeT op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

// word target with upper pc bits left at zero in this small store
function automatic logic [31:0] encodeJ(int target);
    return {opJ, 26'(target)};
endfunction

// unused words jump to themselves
function automatic logic [31:0] fetchWord(int idx);
    return (idx < progLen) ? prog[idx] : encodeJ(idx);
endfunction

// ---------------------------------------------------------------------------
// program builders
// ---------------------------------------------------------------------------
task automatic emit(input logic [31:0] word);
    prog[progLen] = word;
    progLen++;
endtask

task automatic startProgram();
    progLen = 0;
endtask

// every program ends on a self-jump
task automatic finishProgram();
    haltPc = progLen * 4;
    emit(encodeJ(progLen));
endtask

task automatic buildAluProgram();
    startProgram();
    emit(encodeI(opAddi, 1, 0, 100));
    // negative immediate shows sign extension in writeData
    emit(encodeI(opAddi, 2, 0, -7));
    emit(encodeR(fnAdd, 3, 1, 2, 0));
    emit(encodeR(fnSub, 4, 2, 1, 0));
    emit(encodeR(fnAnd, 5, 1, 2, 0));
    emit(encodeR(fnOr, 6, 1, 2, 0));
    // negative operand on either side of slt
    emit(encodeR(fnSlt, 7, 2, 1, 0));
    emit(encodeR(fnSlt, 8, 1, 2, 0));
    emit(encodeR(fnSll, 9, 0, 1, 3));
    emit(encodeR(fnSrl, 10, 0, 2, 4));
    // write to $zero, then read it back
    emit(encodeI(opAddi, 0, 1, 55));
    emit(encodeR(fnAdd, 11, 0, 1, 0));
    finishProgram();
endtask

task automatic buildMemoryProgram();
    startProgram();
    // a store at the reset pc gives the reset check a live memWrite decode
    emit(encodeI(opSw, 0, 0, 0));
    emit(encodeI(opAddi, 1, 0, 8));
    emit(encodeI(opAddi, 2, 0, -123));
    // stores at 12 and 4, then loads from both
    emit(encodeI(opSw, 2, 1, 4));
    emit(encodeI(opSw, 1, 1, -4));
    emit(encodeI(opLw, 3, 1, 4));
    emit(encodeI(opLw, 4, 0, 4));
    emit(encodeR(fnAdd, 5, 3, 4, 0));
    finishProgram();
endtask

task automatic buildBranchProgram();
    startProgram();
    emit(encodeI(opAddi, 1, 0, 5));
    emit(encodeI(opAddi, 2, 0, 5));
    // taken branch skips index 3
    emit(encodeI(opBeq, 2, 1, 1));
    emit(encodeI(opAddi, 3, 0, 1));
    // not taken
    emit(encodeI(opBeq, 0, 1, 1));
    emit(encodeI(opAddi, 4, 0, 2));
    emit(encodeJ(8));
    emit(encodeI(opAddi, 5, 0, 3));
    emit(encodeI(opAddi, 6, 0, 4));
    finishProgram();
endtask

function automatic functT pickFunct(logic [31:0] sel);
    case (sel[2:0])
        3'd1: return fnSub;
        3'd2: return fnAnd;
        3'd3: return fnOr;
        3'd4: return fnSlt;
        3'd5: return fnSll;
        3'd6: return fnSrl;
        default: return fnAdd;
    endcase
endfunction

// addi and R-type mix with register numbers that include $zero
task automatic buildRandomProgram(input int count);
    logic [31:0] dst;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] extra;
    startProgram();
    for (int i = 0; i < count; i++) begin
        dst = takeBits(regAddrWidth);
        src1 = takeBits(regAddrWidth);
        src2 = takeBits(regAddrWidth);
        if (takeBits(1) == 32'd1) begin
            extra = takeBits(immWidth);
            emit(encodeI(opAddi, int'(dst), int'(src1), int'(extra)));
        end else begin
            extra = takeBits(shamtWidth);
            emit(encodeR(pickFunct(takeBits(3)), int'(dst), int'(src1), int'(src2),
                         int'(extra)));
        end
    end
    finishProgram();
endtask

`endif

// File: verification/coreTb.sv
`timescale 1ns/1ps

module coreTb;
    import mipsCfgPkg::*;
    import mipsIsaPkg::*;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 5;
    localparam int runLimit = 200;

    logic                     clk;
    logic                     rstN;
    logic                     progWe;
    logic [imemAddrWidth-1:0] progAddr;
    logic [dataWidth-1:0]     progData;
    logic [dataWidth-1:0]     pc;
    logic                     regWrite;
    logic [regAddrWidth-1:0]  writeReg;
    logic [dataWidth-1:0]     writeData;
    logic [dataWidth-1:0]     readData1;
    logic [dataWidth-1:0]     readData2;
    logic                     memWrite;
    logic [dataWidth-1:0]     memAddr;
    logic [dataWidth-1:0]     memWdata;

    // program under test and reference model state
    logic [dataWidth-1:0] prog [imemDepth];
    int                   progLen;
    logic [dataWidth-1:0] haltPc;
    logic [dataWidth-1:0] mRegs [regCount];
    logic [dataWidth-1:0] mDmem [dmemDepth];
    logic [dataWidth-1:0] mPc;
    logic [31:0]          lfsrState;
    string                testName;

    singleCycleCore DUT (
        .clk(clk),
        .rstN(rstN),
        .progWe(progWe),
        .progAddr(progAddr),
        .progData(progData),
        .pc(pc),
        .regWrite(regWrite),
        .writeReg(writeReg),
        .writeData(writeData),
        .readData1(readData1),
        .readData2(readData2),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWdata(memWdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // random source, x^32 + x^22 + x^2 + x + 1
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit handed out
    function automatic logic [31:0] takeBits(int count);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return bits;
    endfunction

    `include "coreTbPrograms.svh"

    // ------------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------------
    task automatic stopOnFailure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic expectEqual(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", testName, what, expected, actual);
            stopOnFailure();
        end
    endtask

    // model of one instruction, compared against the commit ports
    task automatic checkAndStep();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic [4:0]  dst;
        logic        wr;
        logic        store;
        ins = fetchWord(int'(mPc[2 +: imemAddrWidth]));
        a = mRegs[ins[25:21]];
        b = mRegs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        nextPc = mPc + 32'd4;
        dst = ins[20:16];
        result = '0;
        wr = 1'b0;
        store = 1'b0;
        case (ins[31:26])
            opRtype: begin
                dst = ins[15:11];
                wr = 1'b1;
                case (ins[5:0])
                    fnAdd: result = a + b;
                    fnSub: result = a - b;
                    fnAnd: result = a & b;
                    fnOr: result = a | b;
                    fnSlt: result = {31'b0, $signed(a) < $signed(b)};
                    fnSll: result = b << ins[10:6];
                    fnSrl: result = b >> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            opAddi: begin
                wr = 1'b1;
                result = addr;
            end
            opLw: begin
                wr = 1'b1;
                result = mDmem[addr[2 +: dmemAddrWidth]];
            end
            opSw: store = 1'b1;
            // word offset relative to the next instruction
            opBeq: nextPc = (a == b) ? nextPc + (imm << 2) : nextPc;
            opJ: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
            default: wr = 1'b0;
        endcase
        expectEqual("pc", mPc, pc);
        expectEqual("readData1", a, readData1);
        expectEqual("readData2", b, readData2);
        expectEqual("regWrite", {31'b0, wr}, {31'b0, regWrite});
        expectEqual("memWrite", {31'b0, store}, {31'b0, memWrite});
        if (wr) begin
            expectEqual("writeReg", {27'b0, dst}, {27'b0, writeReg});
            expectEqual("writeData", result, writeData);
            if (dst != 5'd0) begin
                mRegs[dst] = result;
            end
        end
        if (store) begin
            expectEqual("memAddr", addr, memAddr);
            expectEqual("memWdata", b, memWdata);
            mDmem[addr[2 +: dmemAddrWidth]] = b;
        end
        mPc = nextPc;
    endtask

    // ------------------------------------------------------------------------
    // reset, load, run to the halt address
    // ------------------------------------------------------------------------
    task automatic runProgram();
        int   cycles;
        logic halted;
        for (int i = 0; i < resetCycles + imemDepth; i++) begin
            @(negedge clk);
            rstN = 1'b0;
            progWe = (i >= resetCycles);
            progAddr = imemAddrWidth'(i - resetCycles);
            progData = (i >= resetCycles) ? fetchWord(i - resetCycles) : '0;
            @(posedge clk);
            expectEqual("pc in reset", resetPc, pc);
            expectEqual("regWrite in reset", 32'd0, {31'b0, regWrite});
            expectEqual("memWrite in reset", 32'd0, {31'b0, memWrite});
        end
        for (int r = 0; r < regCount; r++) begin
            mRegs[r] = '0;
        end
        mPc = resetPc;
        @(negedge clk);
        progWe = 1'b0;
        rstN = 1'b1;
        cycles = 0;
        halted = 1'b0;
        while (!halted) begin
            @(posedge clk);
            halted = (pc === haltPc);
            checkAndStep();
            cycles++;
            if (!halted && cycles >= runLimit) begin
                $display("%s did not reach its halt address within %0d cycles",
                         testName, runLimit);
                stopOnFailure();
            end
        end
    endtask

    task automatic testAluOps();
        testName = "aluOps";
        buildAluProgram();
        runProgram();
    endtask

    task automatic testMemory();
        testName = "memory";
        buildMemoryProgram();
        runProgram();
    endtask

    task automatic testControlFlow();
        testName = "controlFlow";
        buildBranchProgram();
        runProgram();
    endtask

    task automatic testRandom();
        for (int r = 0; r < 2; r++) begin
            testName = $sformatf("random%0d", r);
            buildRandomProgram(40);
            runProgram();
        end
    endtask

    initial begin
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        progLen = 0;
        haltPc = '0;
        lfsrState = 32'h7add1f95;
        testAluOps();
        testMemory();
        testControlFlow();
        testRandom();
        $display("All tests passed");
        $finish;
    end

endmodule

// File: hdl/singleCycleCore.sv
`timescale 1ns/1ps

module singleCycleCore (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  progWe,
    input  logic [mipsCfgPkg::imemAddrWidth-1:0]  progAddr,
    input  logic [mipsCfgPkg::dataWidth-1:0]      progData,
    output logic [mipsCfgPkg::dataWidth-1:0]      pc,
    output logic                                  regWrite,
    output logic [mipsCfgPkg::regAddrWidth-1:0]   writeReg,
    output logic [mipsCfgPkg::dataWidth-1:0]      writeData,
    output logic [mipsCfgPkg::dataWidth-1:0]      readData1,
    output logic [mipsCfgPkg::dataWidth-1:0]      readData2,
    output logic                                  memWrite,
    output logic [mipsCfgPkg::dataWidth-1:0]      memAddr,
    output logic [mipsCfgPkg::dataWidth-1:0]      memWdata
);
    import mipsCfgPkg::*;
    import mipsIsaPkg::*;

    logic [dataWidth-1:0]       instr;
    logic [opcodeWidth-1:0]     opcodeField;
    logic [regAddrWidth-1:0]    rs;
    logic [regAddrWidth-1:0]    rt;
    logic [regAddrWidth-1:0]    rd;
    logic [shamtWidth-1:0]      shamt;
    logic [immWidth-1:0]        imm;
    logic [jumpTargetWidth-1:0] jumpTarget;
    logic [dataWidth-1:0]       immExt;
    logic [dataWidth-1:0]       aluB;
    logic [dataWidth-1:0]       aluResult;
    logic [dataWidth-1:0]       memRdata;
    logic                       regDst;
    logic                       aluSrc;
    logic                       memToReg;
    logic                       branch;
    logic                       jump;
    logic                       zero;
    opcodeT                     opcode;
    functT                      funct;
    aluOpT                      aluOp;

    // -------------------------------------------------------------------------
    // fetch
    // -------------------------------------------------------------------------
    fetchUnit fetch (
        .clk(clk),
        .rstN(rstN),
        .progWe(progWe),
        .progAddr(progAddr),
        .progData(progData),
        .branchTaken(branch & zero),
        .branchOffset(immExt),
        .jump(jump),
        .jumpTarget(jumpTarget),
        .pc(pc),
        .instr(instr)
    );

    // -------------------------------------------------------------------------
    // field split and sign extension
    // -------------------------------------------------------------------------
    assign opcodeField = instr[opcodeLsb +: opcodeWidth];
    assign rs = instr[rsLsb +: regAddrWidth];
    assign rt = instr[rtLsb +: regAddrWidth];
    assign rd = instr[rdLsb +: regAddrWidth];
    assign shamt = instr[shamtLsb +: shamtWidth];
    assign funct = functT'(instr[functLsb +: functWidth]);
    assign imm = instr[immWidth-1:0];
    assign jumpTarget = instr[jumpTargetWidth-1:0];
    assign immExt = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};

    // in reset the decoder sees an unused opcode, so both write strobes stay low
    assign opcode = rstN ? opcodeT'(opcodeField) : opcodeT'({opcodeWidth{1'b1}});

    // -------------------------------------------------------------------------
    // decode and register read
    // -------------------------------------------------------------------------
    controlUnit control (
        .opcode(opcode),
        .funct(funct),
        .regDst(regDst),
        .aluSrc(aluSrc),
        .memToReg(memToReg),
        .memWrite(memWrite),
        .regWrite(regWrite),
        .branch(branch),
        .jump(jump),
        .aluOp(aluOp)
    );

    // R-type writes rd, I-type writes rt
    assign writeReg = regDst ? rd : rt;

    registerFile regFile (
        .clk(clk),
        .rstN(rstN),
        .readReg1(rs),
        .readReg2(rt),
        .writeReg(writeReg),
        .regWrite(regWrite),
        .writeDataIn(writeData),
        .readData1(readData1),
        .readData2(readData2)
    );

    // -------------------------------------------------------------------------
    // execute, memory, write-back
    // -------------------------------------------------------------------------
    // immediate operand for addi, lw and sw
    assign aluB = aluSrc ? immExt : readData2;

    alu aluUnit (
        .a(readData1),
        .b(aluB),
        .aluOp(aluOp),
        .shamt(shamt),
        .result(aluResult),
        .zero(zero)
    );

    // store data always comes from rt
    assign memAddr = aluResult;
    assign memWdata = readData2;

    dataMemory dmem (
        .clk(clk),
        .memWrite(memWrite),
        .addr(memAddr),
        .wdata(memWdata),
        .rdata(memRdata)
    );

    // load word or ALU result back to the register file
    assign writeData = memToReg ? memRdata : aluResult;

endmodule

// File: hdl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input  logic                             clk,
    input  logic                             memWrite,
    input  logic [mipsCfgPkg::dataWidth-1:0] addr,
    input  logic [mipsCfgPkg::dataWidth-1:0] wdata,
    output logic [mipsCfgPkg::dataWidth-1:0] rdata
);
    import mipsCfgPkg::*;

    logic [dataWidth-1:0] mem [dmemDepth];
    logic [dmemAddrWidth-1:0] wordIdx;

    // byte address to word index, upper bits wrap
    assign wordIdx = addr[byteOffsetWidth +: dmemAddrWidth];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[wordIdx] <= wdata;
        end
    end

    // lw data ready in the same cycle
    assign rdata = mem[wordIdx];

    // word accesses only, base plus offset from the ALU
    storeAligned: assert property (@(posedge clk)
        memWrite |-> (addr[byteOffsetWidth-1:0] == '0));

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [mipsCfgPkg::dataWidth-1:0]  a,
    input  logic [mipsCfgPkg::dataWidth-1:0]  b,
    input  mipsIsaPkg::aluOpT                 aluOp,
    input  logic [mipsIsaPkg::shamtWidth-1:0] shamt,
    output logic [mipsCfgPkg::dataWidth-1:0]  result,
    output logic                              zero
);
    import mipsCfgPkg::*;
    import mipsIsaPkg::*;

    logic lessThan;

    // two's complement compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluSlt: result = {{(dataWidth - 1){1'b0}}, lessThan};
            // shifts act on rt, amount from the shamt field
            aluSll: result = b << shamt;
            aluSrl: result = b >> shamt;
            default: result = '0;
        endcase
    end

    // beq takes the branch on equal operands
    assign zero = (result == '0);

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic [mipsCfgPkg::regAddrWidth-1:0]   readReg1,
    input  logic [mipsCfgPkg::regAddrWidth-1:0]   readReg2,
    input  logic [mipsCfgPkg::regAddrWidth-1:0]   writeReg,
    input  logic                                  regWrite,
    input  logic [mipsCfgPkg::dataWidth-1:0]      writeDataIn,
    output logic [mipsCfgPkg::dataWidth-1:0]      readData1,
    output logic [mipsCfgPkg::dataWidth-1:0]      readData2
);
    import mipsCfgPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // write at the edge that ends the instruction
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (writeReg != '0)) begin
            // $zero is never written
            regs[writeReg] <= writeDataIn;
        end
    end

    // reads see the value before this cycle's write
    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];

    // $zero reads zero on both ports, whatever the core tried to write
    zeroRegReads: assert property (@(posedge clk) disable iff (!rstN)
        ((readReg1 != '0) || (readData1 == '0)) &&
        ((readReg2 != '0) || (readData2 == '0)));

endmodule

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  mipsIsaPkg::opcodeT opcode,
    input  mipsIsaPkg::functT  funct,
    output logic               regDst,
    output logic               aluSrc,
    output logic               memToReg,
    output logic               memWrite,
    output logic               regWrite,
    output logic               branch,
    output logic               jump,
    output mipsIsaPkg::aluOpT  aluOp
);
    import mipsIsaPkg::*;

    aluClassT aluClass;
    logic     regWriteDec;
    logic     functValid;

    always_comb begin
        // -----------------------------------------------------------------
        // main decode, defaults describe a harmless no-op
        // -----------------------------------------------------------------
        regDst = 1'b0;
        aluSrc = 1'b0;
        memToReg = 1'b0;
        memWrite = 1'b0;
        regWriteDec = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        aluClass = clsAdd;
        case (opcode)
            opRtype: begin
                // rd destination, op from funct
                regDst = 1'b1;
                regWriteDec = 1'b1;
                aluClass = clsFunct;
            end
            opAddi: begin
                aluSrc = 1'b1;
                regWriteDec = 1'b1;
            end
            opLw: begin
                // base plus offset, memory word to rt
                aluSrc = 1'b1;
                memToReg = 1'b1;
                regWriteDec = 1'b1;
            end
            opSw: begin
                aluSrc = 1'b1;
                memWrite = 1'b1;
            end
            opBeq: begin
                // compare by subtraction, zero flag decides
                branch = 1'b1;
                aluClass = clsSub;
            end
            opJ: begin
                jump = 1'b1;
            end
            default: begin
                // unknown or reset-forced opcode, nothing written
            end
        endcase

        // -----------------------------------------------------------------
        // ALU operation from class and funct
        // -----------------------------------------------------------------
        functValid = 1'b1;
        case (aluClass)
            clsSub: aluOp = aluSub;
            clsFunct: begin
                case (funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnSlt: aluOp = aluSlt;
                    fnSll: aluOp = aluSll;
                    fnSrl: aluOp = aluSrl;
                    default: begin
                        // unsupported R-type, suppress the write
                        aluOp = aluAdd;
                        functValid = 1'b0;
                    end
                endcase
            end
            default: aluOp = aluAdd;
        endcase

        regWrite = regWriteDec & functValid;

        // a store never also writes back
        writesExclusive: assert (!(memWrite && regWrite));
    end

endmodule

// File: hdl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   progWe,
    input  logic [mipsCfgPkg::imemAddrWidth-1:0]   progAddr,
    input  logic [mipsCfgPkg::dataWidth-1:0]       progData,
    input  logic                                   branchTaken,
    input  logic [mipsCfgPkg::dataWidth-1:0]       branchOffset,
    input  logic                                   jump,
    input  logic [mipsIsaPkg::jumpTargetWidth-1:0] jumpTarget,
    output logic [mipsCfgPkg::dataWidth-1:0]       pc,
    output logic [mipsCfgPkg::dataWidth-1:0]       instr
);
    import mipsCfgPkg::*;
    import mipsIsaPkg::*;

    logic [dataWidth-1:0] imem [imemDepth];
    logic [dataWidth-1:0] pcPlusStep;
    logic [dataWidth-1:0] branchPc;
    logic [dataWidth-1:0] jumpPc;
    logic [dataWidth-1:0] nextPc;

    // next-PC candidates
    assign pcPlusStep = pc + pcStep;
    // offset counts words, relative to the following instruction
    assign branchPc = pcPlusStep + (branchOffset << byteOffsetWidth);
    // region bits of pc+4 joined with the word target
    assign jumpPc = {pcPlusStep[dataWidth-1 -: (dataWidth - jumpTargetWidth - byteOffsetWidth)],
                     jumpTarget,
                     {byteOffsetWidth{1'b0}}};

    // jump wins, beq and j never decode together anyway
    always_comb begin
        if (jump) begin
            nextPc = jumpPc;
        end else if (branchTaken) begin
            nextPc = branchPc;
        end else begin
            nextPc = pcPlusStep;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // program load port, usable while the core sits in reset
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // combinational fetch at the word index of pc
    assign instr = imem[pc[byteOffsetWidth +: imemAddrWidth]];

    // branch and jump targets must keep word alignment
    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        pc[byteOffsetWidth-1:0] == '0);

    // loading while running would change instructions under the core
    loadOnlyInReset: assert property (@(posedge clk) rstN |-> !progWe);

endmodule

// File: hdl/mipsCfgPkg.sv
package mipsCfgPkg;

    // -------------------------------------------------------------------------
    // machine sizes
    // -------------------------------------------------------------------------
    // one word for registers, ALU and memories
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 2 ** regAddrWidth;
    // instruction store, PC truncated to its word index
    localparam int imemDepth = 64;
    localparam int imemAddrWidth = $clog2(imemDepth);
    // data store
    localparam int dmemDepth = 64;
    localparam int dmemAddrWidth = $clog2(dmemDepth);
    // byte offset inside a word
    localparam int byteOffsetWidth = 2;
    // fetch sequencing
    localparam logic [dataWidth-1:0] resetPc = '0;
    localparam logic [dataWidth-1:0] pcStep = 32'd4;

endpackage

// File: hdl/mipsIsaPkg.sv
package mipsIsaPkg;

    // -------------------------------------------------------------------------
    // instruction field positions
    // -------------------------------------------------------------------------
    localparam int opcodeLsb = 26;
    localparam int opcodeWidth = 6;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int shamtLsb = 6;
    localparam int shamtWidth = 5;
    localparam int functLsb = 0;
    localparam int functWidth = 6;
    // I-type immediate sits in the low half
    localparam int immWidth = 16;
    // J-type word target
    localparam int jumpTargetWidth = 26;

    // -------------------------------------------------------------------------
    // encodings
    // -------------------------------------------------------------------------
    typedef enum logic [opcodeWidth-1:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // R-type funct field
    typedef enum logic [functWidth-1:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    // coarse class from the main decoder
    typedef enum logic [1:0] {
        clsAdd   = 2'b00,
        clsSub   = 2'b01,
        clsFunct = 2'b10
    } aluClassT;

    // operation select seen by the ALU
    typedef enum logic [3:0] {
        aluAnd = 4'h0,
        aluOr  = 4'h1,
        aluAdd = 4'h2,
        aluSub = 4'h6,
        aluSlt = 4'h7,
        aluSll = 4'h8,
        aluSrl = 4'h9
    } aluOpT;

endpackage
